// ==== Makefile ====
# Verilator build and run for the I2C bridge testbench

SIM = obj_dir/i2c_bridge_sim

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f compile.f \
		--top-module i2c_bridge_tb -o i2c_bridge_sim

run: compile
	./$(SIM) | tee sim.log
	@if grep -q "FAIL: see errors above" sim.log; then \
		echo "Simulation failed"; exit 1; \
	fi
	@if ! grep -q "PASS: all tests" sim.log; then \
		echo "Simulation did not complete"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// ==== compile.f ====
source/ctrl_pkg.sv
source/i2c_pkg.sv
source/i2c_cmd_seq.sv
source/i2c_master.sv
source/i2c_bridge_top.sv
test/i2c_bridge_sva.sv
test/i2c_bridge_tb.sv

// ==== source/ctrl_pkg.sv ====
package ctrl_pkg;

  // Host register map
  localparam logic [5:0] REG_DIRECT = 6'h3d;
  localparam logic [5:0] REG_FILTER = 6'h00;

  // Opcode required in data[31:24] of a direct write
  localparam logic [7:0] OP_DIRECT = 8'h06;

  // Filter device and its register index
  localparam logic [6:0] FILTER_DEV = 7'h20;
  localparam logic [7:0] FILTER_REG = 8'h0a;

  // Sequencer states
  typedef enum logic [2:0] {
    IDLE,
    ADDR,
    DATA0,
    DATA1,
    DATA2
  } seq_state_e;

endpackage

// ==== source/i2c_bridge_top.sv ====
`timescale 1ns/1ns

module i2c_bridge_top (
  input  logic              clk,
  input  logic              rst,
  input  logic [5:0]        cmd_addr_i,
  input  logic [31:0]       cmd_data_i,
  input  logic              cmd_rqst_i,
  output logic              cmd_ack_o,
  input  logic              scl_i,
  input  logic              sda_i,
  output i2c_pkg::i2c_pad_t pad_o,
  output logic              busy_o,
  output logic              nack_o
);

  logic               mst_busy;
  logic [6:0]         mst_addr;
  logic               mst_cmd_valid;
  logic               mst_cmd_ready;
  i2c_pkg::i2c_byte_t mst_byte;
  logic               mst_byte_valid;
  logic               mst_byte_ready;

  i2c_cmd_seq u_seq (
    .clk              (clk),
    .rst              (rst),
    .cmd_addr_i       (cmd_addr_i),
    .cmd_data_i       (cmd_data_i),
    .cmd_rqst_i       (cmd_rqst_i),
    .cmd_ack_o        (cmd_ack_o),
    .mst_busy_i       (mst_busy),
    .mst_addr_o       (mst_addr),
    .mst_cmd_valid_o  (mst_cmd_valid),
    .mst_cmd_ready_i  (mst_cmd_ready),
    .mst_byte_o       (mst_byte),
    .mst_byte_valid_o (mst_byte_valid),
    .mst_byte_ready_i (mst_byte_ready),
    .busy_o           (busy_o)
  );

  i2c_master u_master (
    .clk          (clk),
    .rst          (rst),
    .addr_i       (mst_addr),
    .cmd_valid_i  (mst_cmd_valid),
    .cmd_ready_o  (mst_cmd_ready),
    .byte_i       (mst_byte),
    .byte_valid_i (mst_byte_valid),
    .byte_ready_o (mst_byte_ready),
    .scl_i        (scl_i),
    .sda_i        (sda_i),
    .pad_o        (pad_o),
    .busy_o       (mst_busy),
    .nack_o       (nack_o)
  );

endmodule

// ==== source/i2c_cmd_seq.sv ====
`timescale 1ns/1ns

module i2c_cmd_seq (
  input  logic               clk,
  input  logic               rst,
  input  logic [5:0]         cmd_addr_i,
  input  logic [31:0]        cmd_data_i,
  input  logic               cmd_rqst_i,
  output logic               cmd_ack_o,
  input  logic               mst_busy_i,
  output logic [6:0]         mst_addr_o,
  output logic               mst_cmd_valid_o,
  input  logic               mst_cmd_ready_i,
  output i2c_pkg::i2c_byte_t mst_byte_o,
  output logic               mst_byte_valid_o,
  input  logic               mst_byte_ready_i,
  output logic               busy_o
);

  ctrl_pkg::seq_state_e state_q;

  logic [6:0] filter_sel_q;
  logic       ack_q;
  logic       three_q;
  logic [6:0] dev_q;
  logic [7:0] byte0_q;
  logic [7:0] byte1_q;
  logic       filter_hit;
  logic       direct_hit;
  logic       need_xfer;
  logic       start;

  // Request decode
  assign filter_hit = cmd_rqst_i && (cmd_addr_i == ctrl_pkg::REG_FILTER) &&
                      (cmd_data_i[23:17] != filter_sel_q);
  assign direct_hit = cmd_rqst_i && (cmd_addr_i == ctrl_pkg::REG_DIRECT) &&
                      (cmd_data_i[31:24] == ctrl_pkg::OP_DIRECT);
  assign need_xfer  = filter_hit || direct_hit;
  assign start      = (state_q == ctrl_pkg::IDLE) && need_xfer && !mst_busy_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q      <= ctrl_pkg::IDLE;
      filter_sel_q <= 7'h00;
      ack_q        <= 1'b0;
      three_q      <= 1'b0;
    end else begin
      // Missed only when a transaction was needed but the master was busy
      if (state_q == ctrl_pkg::IDLE && cmd_rqst_i) begin
        ack_q <= !(need_xfer && mst_busy_i);
      end
      case (state_q)
        ctrl_pkg::IDLE: begin
          if (start) begin
            state_q <= ctrl_pkg::ADDR;
            three_q <= filter_hit;
            if (filter_hit) begin
              filter_sel_q <= cmd_data_i[23:17];
            end
          end
        end
        ctrl_pkg::ADDR: begin
          if (mst_cmd_ready_i) begin
            state_q <= ctrl_pkg::DATA0;
          end
        end
        ctrl_pkg::DATA0: begin
          if (mst_byte_ready_i) begin
            state_q <= ctrl_pkg::DATA1;
          end
        end
        ctrl_pkg::DATA1: begin
          if (mst_byte_ready_i) begin
            state_q <= three_q ? ctrl_pkg::DATA2 : ctrl_pkg::IDLE;
          end
        end
        ctrl_pkg::DATA2: begin
          if (mst_byte_ready_i) begin
            state_q <= ctrl_pkg::IDLE;
          end
        end
        default: state_q <= ctrl_pkg::IDLE;
      endcase
    end
  end

  // Transaction payload, filter rule takes priority
  always_ff @(posedge clk) begin
    if (start) begin
      if (filter_hit) begin
        dev_q   <= ctrl_pkg::FILTER_DEV;
        byte0_q <= ctrl_pkg::FILTER_REG;
        byte1_q <= {1'b0, cmd_data_i[23:17]};
      end else begin
        dev_q   <= cmd_data_i[22:16];
        byte0_q <= cmd_data_i[15:8];
        byte1_q <= cmd_data_i[7:0];
      end
    end
  end

  always_comb begin
    mst_byte_o.data = byte0_q;
    mst_byte_o.last = 1'b0;
    case (state_q)
      ctrl_pkg::DATA1: begin
        mst_byte_o.data = byte1_q;
        mst_byte_o.last = !three_q;
      end
      // Filter write ends with a zero byte
      ctrl_pkg::DATA2: begin
        mst_byte_o.data = 8'h00;
        mst_byte_o.last = 1'b1;
      end
      default: ;
    endcase
  end

  assign mst_addr_o       = dev_q;
  assign mst_cmd_valid_o  = (state_q == ctrl_pkg::ADDR);
  assign mst_byte_valid_o = (state_q == ctrl_pkg::DATA0) || (state_q == ctrl_pkg::DATA1) ||
                            (state_q == ctrl_pkg::DATA2);
  assign cmd_ack_o        = ack_q;
  assign busy_o           = (state_q != ctrl_pkg::IDLE) || mst_busy_i;

endmodule

// ==== source/i2c_master.sv ====
`timescale 1ns/1ns

module i2c_master (
  input  logic               clk,
  input  logic               rst,
  input  logic [6:0]         addr_i,
  input  logic               cmd_valid_i,
  output logic               cmd_ready_o,
  input  i2c_pkg::i2c_byte_t byte_i,
  input  logic               byte_valid_i,
  output logic               byte_ready_o,
  input  logic               scl_i,
  input  logic               sda_i,
  output i2c_pkg::i2c_pad_t  pad_o,
  output logic               busy_o,
  output logic               nack_o
);

  i2c_pkg::mst_state_e state_q;

  logic [15:0] qcnt_q;
  logic [1:0]  phase_q;
  logic [2:0]  bit_q;
  logic [7:0]  shift_q;
  logic        last_q;
  logic        nack_seen_q;
  logic        drain_q;
  logic        scl_q;
  logic        sda_q;
  logic        nack_q;
  logic        stretch;
  logic        tick;
  logic        need_byte;
  logic        hold;
  logic        adv;

  // Slave holds SCL low after we released it
  assign stretch   = scl_q && !scl_i;
  assign tick      = (state_q != i2c_pkg::IDLE) && (qcnt_q == 16'd0) && !stretch;
  assign need_byte = !nack_seen_q && !last_q;

  // Stay in the last quarter until the next byte or the drain is done
  always_comb begin
    hold = 1'b0;
    if (state_q == i2c_pkg::ACK && phase_q == 2'd3 && need_byte && !byte_valid_i) begin
      hold = 1'b1;
    end
    if (state_q == i2c_pkg::STOP && phase_q == 2'd3 && drain_q) begin
      hold = 1'b1;
    end
  end

  assign adv = tick && !hold;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q     <= i2c_pkg::IDLE;
      qcnt_q      <= 16'd0;
      phase_q     <= 2'd0;
      bit_q       <= 3'd0;
      last_q      <= 1'b0;
      nack_seen_q <= 1'b0;
      drain_q     <= 1'b0;
      scl_q       <= 1'b1;
      sda_q       <= 1'b1;
      nack_q      <= 1'b0;
    end else begin
      nack_q <= 1'b0;
      if (state_q != i2c_pkg::IDLE && !stretch) begin
        qcnt_q <= (qcnt_q == 16'd0) ? i2c_pkg::PRESCALE : qcnt_q - 16'd1;
      end
      if (adv) begin
        phase_q <= phase_q + 2'd1;
      end
      case (state_q)
        i2c_pkg::IDLE: begin
          if (cmd_valid_i) begin
            state_q     <= i2c_pkg::START;
            qcnt_q      <= i2c_pkg::PRESCALE;
            phase_q     <= 2'd0;
            bit_q       <= 3'd0;
            last_q      <= 1'b0;
            nack_seen_q <= 1'b0;
          end
        end
        // SDA falls at mid-period while SCL is high
        i2c_pkg::START: begin
          if (adv && phase_q == 2'd1) begin
            sda_q <= 1'b0;
          end
          if (adv && phase_q == 2'd3) begin
            scl_q   <= 1'b0;
            state_q <= i2c_pkg::ADDR;
          end
        end
        i2c_pkg::ADDR, i2c_pkg::DATA: begin
          if (adv) begin
            case (phase_q)
              2'd0: sda_q <= shift_q[7];
              2'd1: scl_q <= 1'b1;
              2'd3: begin
                scl_q <= 1'b0;
                bit_q <= bit_q + 3'd1;
                if (bit_q == 3'd7) begin
                  state_q <= i2c_pkg::ACK;
                end
              end
              default: ;
            endcase
          end
        end
        i2c_pkg::ACK: begin
          if (adv) begin
            case (phase_q)
              2'd0: sda_q <= 1'b1;
              2'd1: scl_q <= 1'b1;
              2'd2: begin
                nack_seen_q <= sda_i;
                nack_q      <= sda_i;
                // Remaining bytes are still taken from the sequencer
                if (sda_i && !last_q) begin
                  drain_q <= 1'b1;
                end
              end
              default: begin
                scl_q <= 1'b0;
                if (need_byte) begin
                  last_q  <= byte_i.last;
                  state_q <= i2c_pkg::DATA;
                end else begin
                  state_q <= i2c_pkg::STOP;
                end
              end
            endcase
          end
        end
        i2c_pkg::STOP: begin
          if (drain_q && byte_valid_i && byte_i.last) begin
            drain_q <= 1'b0;
          end
          if (adv) begin
            case (phase_q)
              2'd0: sda_q <= 1'b0;
              2'd1: scl_q <= 1'b1;
              2'd2: sda_q <= 1'b1;
              default: state_q <= i2c_pkg::IDLE;
            endcase
          end
        end
        default: state_q <= i2c_pkg::IDLE;
      endcase
    end
  end

  // Shift register, address plus write bit or the accepted byte
  always_ff @(posedge clk) begin
    if (state_q == i2c_pkg::IDLE && cmd_valid_i) begin
      shift_q <= {addr_i, 1'b0};
    end else if (state_q == i2c_pkg::ACK && adv && phase_q == 2'd3 && need_byte) begin
      shift_q <= byte_i.data;
    end else if ((state_q == i2c_pkg::ADDR || state_q == i2c_pkg::DATA) && adv &&
                 phase_q == 2'd3) begin
      shift_q <= {shift_q[6:0], 1'b0};
    end
  end

  assign cmd_ready_o  = (state_q == i2c_pkg::IDLE);
  assign byte_ready_o = (state_q == i2c_pkg::ACK && phase_q == 2'd3 && tick && need_byte) ||
                        (state_q == i2c_pkg::STOP && drain_q);

  assign pad_o.scl_o = 1'b0;
  assign pad_o.scl_t = scl_q;
  assign pad_o.sda_o = 1'b0;
  assign pad_o.sda_t = sda_q;

  assign busy_o = (state_q != i2c_pkg::IDLE);
  assign nack_o = nack_q;

endmodule

// ==== source/i2c_pkg.sv ====
package i2c_pkg;

  // One byte of a write transaction
  typedef struct packed {
    logic [7:0] data;
    logic       last;
  } i2c_byte_t;

  // Open-drain pad controls, t = 1 releases the line
  typedef struct packed {
    logic scl_o;
    logic scl_t;
    logic sda_o;
    logic sda_t;
  } i2c_pad_t;

  // Master states
  typedef enum logic [2:0] {
    IDLE,
    START,
    ADDR,
    DATA,
    ACK,
    STOP
  } mst_state_e;

  // Clock cycles per quarter SCL period are PRESCALE + 1
  localparam logic [15:0] PRESCALE = 16'd2;

endpackage

// ==== test/i2c_bridge_sva.sv ====
`timescale 1ns/1ns

module i2c_bridge_sva (
  input logic                clk,
  input logic                rst,
  input logic                byte_valid,
  input logic                byte_ready,
  input i2c_pkg::i2c_byte_t  byte_in,
  input logic                scl,
  input logic                sda,
  input i2c_pkg::mst_state_e state,
  input logic                nack
);

  // Valid and payload hold until ready
  assert property (@(posedge clk) disable iff (rst)
    byte_valid && !byte_ready |=> byte_valid && $stable(byte_in))
    else $error("byte valid dropped or byte changed before ready");

  // SDA moves under high SCL only for start and stop
  assert property (@(posedge clk) disable iff (rst)
    scl && $past(scl) && $changed(sda) |->
      (state == i2c_pkg::START || state == i2c_pkg::STOP))
    else $error("SDA changed while SCL high outside start or stop");

  assert property (@(posedge clk) disable iff (rst) nack |=> !nack)
    else $error("nack pulse longer than one cycle");

endmodule

bind i2c_master i2c_bridge_sva u_sva (
  .clk        (clk),
  .rst        (rst),
  .byte_valid (byte_valid_i),
  .byte_ready (byte_ready_o),
  .byte_in    (byte_i),
  .scl        (scl_i),
  .sda        (sda_i),
  .state      (state_q),
  .nack       (nack_o)
);

// ==== test/i2c_bridge_tb.sv ====
`timescale 1ns/1ns

module i2c_bridge_tb;

  logic              clk;
  logic              rst;
  logic [5:0]        cmd_addr;
  logic [31:0]       cmd_data;
  logic              cmd_rqst;
  logic              cmd_ack;
  logic              busy;
  logic              nack;
  i2c_pkg::i2c_pad_t pad;
  logic              slave_scl;
  logic              slave_sda;
  wire               scl;
  wire               sda;

  logic [31:0] seed;
  logic [31:0] rnd;
  logic [31:0] r;
  logic [6:0]  filter_model;
  logic [6:0]  dev;
  logic [6:0]  sel;
  int          errors;
  int          nack_cnt;
  int          nack_before;

  // Bus log entries: kind 1 address byte, 0 data byte, 2 stop
  logic [9:0] got_q[$];
  logic [9:0] exp_q[$];

  // Slave model state
  logic       scl_d;
  logic       sda_d;
  logic [3:0] bitn;
  logic [7:0] shreg;
  logic       acking;
  logic       first;
  logic [3:0] rx_count;
  logic       stretching;
  logic [2:0] str_cnt;

  // Open-drain wired-AND
  assign scl = (pad.scl_t | pad.scl_o) & slave_scl;
  assign sda = (pad.sda_t | pad.sda_o) & slave_sda;

  i2c_bridge_top UUT (
    .clk        (clk),
    .rst        (rst),
    .cmd_addr_i (cmd_addr),
    .cmd_data_i (cmd_data),
    .cmd_rqst_i (cmd_rqst),
    .cmd_ack_o  (cmd_ack),
    .scl_i      (scl),
    .sda_i      (sda),
    .pad_o      (pad),
    .busy_o     (busy),
    .nack_o     (nack)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed;
  endfunction

  always @(posedge clk) begin
    if (!rst && nack) begin
      nack_cnt <= nack_cnt + 1;
    end
  end

  // Slave: sample lines each clock, ACK all but device 0x55
  always @(posedge clk) begin
    if (rst) begin
      slave_scl  <= 1'b1;
      slave_sda  <= 1'b1;
      scl_d      <= 1'b1;
      sda_d      <= 1'b1;
      bitn       <= 4'd0;
      acking     <= 1'b0;
      first      <= 1'b0;
      rx_count   <= 4'd0;
      stretching <= 1'b0;
      str_cnt    <= 3'd0;
    end else begin
      scl_d <= scl;
      sda_d <= sda;
      // Hold SCL a few cycles past the master's release
      if (stretching && pad.scl_t) begin
        if (str_cnt == 3'd0) begin
          stretching <= 1'b0;
          slave_scl  <= 1'b1;
        end else begin
          str_cnt <= str_cnt - 3'd1;
        end
      end
      if (scl && scl_d && sda_d && !sda) begin
        bitn     <= 4'd0;
        acking   <= 1'b0;
        first    <= 1'b1;
        rx_count <= 4'd0;
      end else if (scl && scl_d && !sda_d && sda) begin
        got_q.push_back({2'd2, 8'h00});
        rx_count <= 4'd0;
      end else if (scl && !scl_d && bitn < 4'd8) begin
        shreg <= {shreg[6:0], sda};
        bitn  <= bitn + 4'd1;
      end else if (!scl && scl_d) begin
        if (bitn == 4'd8 && !acking) begin
          got_q.push_back({first ? 2'd1 : 2'd0, shreg});
          rx_count <= rx_count + 4'd1;
          acking   <= 1'b1;
          if (!(first && shreg == 8'haa)) begin
            slave_sda <= 1'b0;
          end
        end else if (acking) begin
          slave_sda <= 1'b1;
          acking    <= 1'b0;
          bitn      <= 4'd0;
          first     <= 1'b0;
          rnd = lcg_next();
          if (rnd[4]) begin
            stretching <= 1'b1;
            slave_scl  <= 1'b0;
            str_cnt    <= rnd[2:0];
          end
        end
      end
    end
  end

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("FAILED %s expected %0h actual %0h", name, exp, act);
      errors++;
    end
  endtask

  // Reference decode, then one request cycle and the ack check
  task automatic send_req(input string name, input logic [5:0] a, input logic [31:0] d,
                          input logic in_busy);
    logic need_f;
    logic need_d;
    logic exp_ack;
    need_f = (a == ctrl_pkg::REG_FILTER) && (d[23:17] != filter_model);
    need_d = (a == ctrl_pkg::REG_DIRECT) && (d[31:24] == ctrl_pkg::OP_DIRECT);
    exp_ack = !((need_f || need_d) && in_busy);
    if (need_f && !in_busy) begin
      filter_model = d[23:17];
      exp_q.push_back({2'd1, ctrl_pkg::FILTER_DEV, 1'b0});
      exp_q.push_back({2'd0, ctrl_pkg::FILTER_REG});
      exp_q.push_back({2'd0, 1'b0, d[23:17]});
      exp_q.push_back({2'd0, 8'h00});
      exp_q.push_back({2'd2, 8'h00});
    end else if (need_d && !in_busy) begin
      exp_q.push_back({2'd1, d[22:16], 1'b0});
      if (d[22:16] != 7'h55) begin
        exp_q.push_back({2'd0, d[15:8]});
        exp_q.push_back({2'd0, d[7:0]});
      end
      exp_q.push_back({2'd2, 8'h00});
    end
    @(posedge clk);
    cmd_addr <= a;
    cmd_data <= d;
    cmd_rqst <= 1'b1;
    @(posedge clk);
    cmd_rqst <= 1'b0;
    @(negedge clk);
    check_val({name, " ack"}, {31'd0, exp_ack}, {31'd0, cmd_ack});
  endtask

  task automatic wait_idle(input string name);
    int i;
    for (i = 0; i < 5000 && busy; i++) begin
      @(negedge clk);
    end
    if (busy) begin
      $display("Timeout in %s: busy never fell", name);
      errors++;
    end
  endtask

  task automatic wait_bytes(input logic [3:0] n);
    int i;
    for (i = 0; i < 5000 && rx_count < n; i++) begin
      @(negedge clk);
    end
    if (rx_count < n) begin
      $display("Timeout: slave did not receive %0d bytes", n);
      errors++;
    end
  endtask

  initial begin
    clk          = 1'b0;
    rst          = 1'b1;
    cmd_addr     = 6'd0;
    cmd_data     = 32'd0;
    cmd_rqst     = 1'b0;
    seed         = 32'h6a7e;
    filter_model = 7'h00;
    errors       = 0;
    nack_cnt     = 0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_val("reset scl_t", 32'd1, {31'd0, pad.scl_t});
    check_val("reset sda_t", 32'd1, {31'd0, pad.sda_t});
    check_val("reset ack", 32'd0, {31'd0, cmd_ack});
    check_val("reset busy", 32'd0, {31'd0, busy});
    check_val("reset nack", 32'd0, {31'd0, nack});

    // Direct writes with random stretching
    repeat (6) begin
      r = lcg_next();
      dev = (r[22:16] == 7'h55) ? 7'h56 : r[22:16];
      send_req("direct", ctrl_pkg::REG_DIRECT, {ctrl_pkg::OP_DIRECT, 1'b0, dev, r[15:0]}, 1'b0);
      wait_idle("direct");
    end

    // Filter change, then the same value again
    r = lcg_next();
    sel = (r[6:0] == 7'h00) ? 7'h13 : r[6:0];
    send_req("filter", ctrl_pkg::REG_FILTER, {8'h00, sel, 17'h0}, 1'b0);
    wait_idle("filter");
    send_req("filter repeat", ctrl_pkg::REG_FILTER, {8'h00, sel, 17'h0}, 1'b0);
    check_val("filter repeat busy", 32'd0, {31'd0, busy});

    // Refused while the master finishes, filter value kept
    send_req("busy direct", ctrl_pkg::REG_DIRECT, {ctrl_pkg::OP_DIRECT, 24'h31_a5c3}, 1'b0);
    wait_bytes(4'd3);
    send_req("busy refuse", ctrl_pkg::REG_FILTER, {8'h00, ~sel, 17'h0}, 1'b1);
    wait_idle("busy refuse");
    send_req("after refuse", ctrl_pkg::REG_FILTER, {8'h00, ~sel, 17'h0}, 1'b0);
    wait_idle("after refuse");

    // NACK on device 0x55
    nack_before = nack_cnt;
    send_req("nack", ctrl_pkg::REG_DIRECT, {ctrl_pkg::OP_DIRECT, 24'h55_1234}, 1'b0);
    wait_idle("nack");
    check_val("nack pulses", 32'd1, nack_cnt - nack_before);
    send_req("after nack", ctrl_pkg::REG_DIRECT, {ctrl_pkg::OP_DIRECT, 24'h2c_5a0f}, 1'b0);
    wait_idle("after nack");

    // Requests that decode to nothing
    repeat (4) begin
      r = lcg_next();
      send_req("ignored", (r[5:0] == 6'h00 || r[5:0] == 6'h3d) ? 6'h11 : r[5:0], r, 1'b0);
      check_val("ignored busy", 32'd0, {31'd0, busy});
    end
    send_req("bad opcode", ctrl_pkg::REG_DIRECT, {8'h07, 24'h12_3456}, 1'b0);
    check_val("bad opcode busy", 32'd0, {31'd0, busy});
    repeat (20) @(negedge clk);

    check_val("bus entries", exp_q.size(), got_q.size());
    for (int i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
      check_val("bus", {22'd0, exp_q[i]}, {22'd0, got_q[i]});
    end

    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule
